// ==== design/rv_isa_pkg.sv ====
// ============================================================
// rv32i subset definitions: data width, reset pc,
// opcode and alu enums, pipeline register structs
// ============================================================
`default_nettype none

package rv_isa_pkg;

   localparam int unsigned     XLEN     = 32;
   localparam logic [XLEN-1:0] RESET_PC = 32'h0;

   // major opcodes, instr[6:0]
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   // alu functions, pass_b forwards operand b (lui)
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_e;

   // fetch -> decode
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [31:0]     instr;
   } if_id_t;

   // decode -> execute
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] pc;
      logic [4:0]      rs1;
      logic [4:0]      rs2;
      logic [XLEN-1:0] rs1_data;
      logic [XLEN-1:0] rs2_data;
      logic [XLEN-1:0] imm;
      alu_op_e         alu_op;
      logic [4:0]      rd;
      logic            reg_we;
      logic            is_load;
      logic            is_store;
      logic            is_branch;
      logic            branch_ne;
      logic            is_jal;
      logic            use_imm;
   } id_ex_t;

   // execute -> memory/writeback, result doubles as the address
   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] result;
      logic [XLEN-1:0] store_data;
      logic [4:0]      rd;
      logic            reg_we;
      logic            is_load;
      logic            is_store;
   } ex_mem_t;

endpackage

`default_nettype wire

// ==== design/rv_bus_pkg.sv ====
// ============================================================
// wishbone classic request/response structs, word select
// and arbiter state encoding
// ============================================================
`default_nettype none

package rv_bus_pkg;

   // all transfers in this core are full words
   localparam logic [3:0] SEL_WORD = 4'b1111;

   // master -> slave
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   // slave -> master
   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   // bus owner
   typedef enum logic [1:0] {
      IDLE,
      GNT_FETCH,
      GNT_DATA
   } arb_state_e;

endpackage

`default_nettype wire

// ==== design/rv_fetch.sv ====
// ============================================================
// fetch stage: program counter, wishbone read master,
// one-entry skid buffer and fetch/decode register
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
   import rv_isa_pkg::*, rv_bus_pkg::*;
(
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire              i_stall,
   input  wire              i_redirect,
   input  wire  [XLEN-1:0]  i_target,
   output if_id_t           o_if_id,
   output wb_req_t          o_wb,
   input  wire  wb_rsp_t    i_wb
);

   logic            cyc_q;
   logic            stale_q;
   logic [XLEN-1:0] pc_q;
   logic [XLEN-1:0] adr_q;
   if_id_t          out_q;
   if_id_t          buf_q;
   logic            ack_live;

   // ack of a read that still belongs to the current path
   assign ack_live = i_wb.ack && cyc_q && !stale_q;

   // read only, address held in adr_q until ack
   assign o_wb = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, sel: SEL_WORD, adr: adr_q, dat: '0};
   assign o_if_id = out_q;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         pc_q        <= RESET_PC;
         cyc_q       <= 1'b0;
         stale_q     <= 1'b0;
         out_q.valid <= 1'b0;
         buf_q.valid <= 1'b0;
      end
      else
      begin
         // bus side, one read outstanding
         if (cyc_q)
         begin
            if (i_wb.ack)
            begin
               cyc_q   <= 1'b0;
               stale_q <= 1'b0;
            end
            else if (i_redirect)
               // old-path read keeps running, its data is dropped
               stale_q <= 1'b1;
         end
         else if (!buf_q.valid && !i_redirect)
         begin
            cyc_q <= 1'b1;
            adr_q <= pc_q;
            pc_q  <= pc_q + 32'd4;
         end
         if (i_redirect)
            pc_q <= i_target;

         // output side
         if (i_redirect)
         begin
            out_q.valid <= 1'b0;
            buf_q.valid <= 1'b0;
         end
         else if (!i_stall)
         begin
            if (buf_q.valid)
            begin
               out_q       <= buf_q;
               buf_q.valid <= 1'b0;
            end
            else if (ack_live)
               out_q <= '{valid: 1'b1, pc: adr_q, instr: i_wb.dat};
            else
               out_q.valid <= 1'b0;
         end
         else if (ack_live)
            // decode frozen, park the word
            buf_q <= '{valid: 1'b1, pc: adr_q, instr: i_wb.dat};
      end
   end

   // a started read stays on the bus unchanged until its ack
   a_req_held : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb.stb && !i_wb.ack |=> o_wb.stb && o_wb.cyc && $stable(o_wb.adr))
      else $error("fetch read dropped or changed address before ack");

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
// ============================================================
// decode stage: opcode and alu decode, immediates,
// write-through register file, load-use stall
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module rv_decode
   import rv_isa_pkg::*;
(
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire  if_id_t     i_if_id,
   input  wire              i_hold,
   input  wire              i_flush,
   input  wire              i_wb_we,
   input  wire  [4:0]       i_wb_rd,
   input  wire  [XLEN-1:0]  i_wb_data,
   output id_ex_t           o_id_ex,
   output logic             o_stall
);

   // x0 has no storage
   logic [XLEN-1:0] regs [1:31];
   logic [31:0]     instr;
   opcode_e         opc;
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [4:0]      rd;
   logic [2:0]      funct3;
   logic [XLEN-1:0] imm_i;
   logic [XLEN-1:0] imm_s;
   logic [XLEN-1:0] imm_b;
   logic [XLEN-1:0] imm_j;
   logic [XLEN-1:0] imm_u;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;
   id_ex_t          dec;
   id_ex_t          id_ex_q;

   // funct3 to alu function, sub only for register ops
   function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
      case (f3)
         3'b000:  alu_sel = sub ? ALU_SUB : ALU_ADD;
         3'b010:  alu_sel = ALU_SLT;
         3'b100:  alu_sel = ALU_XOR;
         3'b110:  alu_sel = ALU_OR;
         3'b111:  alu_sel = ALU_AND;
         default: alu_sel = ALU_ADD;
      endcase
   endfunction

   assign instr  = i_if_id.instr;
   assign opc    = opcode_e'(instr[6:0]);
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   // sign extended immediates
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_u = {instr[31:12], 12'd0};

   // read ports, a same-cycle write is passed straight through
   assign rs1_data = (rs1 == 5'd0) ? '0 :
                     (i_wb_we && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
   assign rs2_data = (rs2 == 5'd0) ? '0 :
                     (i_wb_we && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

   always_ff @(posedge clk)
   begin
      if (i_wb_we && i_wb_rd != 5'd0)
         regs[i_wb_rd] <= i_wb_data;
   end

   always_comb
   begin
      dec          = '0;
      dec.valid    = i_if_id.valid;
      dec.pc       = i_if_id.pc;
      dec.rs1      = rs1;
      dec.rs2      = rs2;
      dec.rs1_data = rs1_data;
      dec.rs2_data = rs2_data;
      dec.rd       = rd;
      dec.alu_op   = ALU_ADD;
      case (opc)
         OPC_OP:
         begin
            dec.alu_op = alu_sel(funct3, instr[30]);
            dec.reg_we = 1'b1;
         end
         OPC_OP_IMM:
         begin
            dec.alu_op  = alu_sel(funct3, 1'b0);
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            dec.reg_we  = 1'b1;
         end
         OPC_LUI:
         begin
            dec.alu_op  = ALU_PASS_B;
            dec.imm     = imm_u;
            dec.use_imm = 1'b1;
            dec.reg_we  = 1'b1;
         end
         OPC_LOAD:
         begin
            dec.imm     = imm_i;
            dec.use_imm = 1'b1;
            dec.is_load = 1'b1;
            dec.reg_we  = 1'b1;
         end
         OPC_STORE:
         begin
            dec.imm      = imm_s;
            dec.use_imm  = 1'b1;
            dec.is_store = 1'b1;
         end
         OPC_BRANCH:
         begin
            dec.imm       = imm_b;
            dec.is_branch = 1'b1;
            // funct3 bit 0 tells bne from beq
            dec.branch_ne = funct3[0];
         end
         OPC_JAL:
         begin
            dec.imm    = imm_j;
            dec.is_jal = 1'b1;
            dec.reg_we = 1'b1;
         end
         default:
            // unknown opcode runs as a nop
            dec.reg_we = 1'b0;
      endcase
      if (rd == 5'd0)
         dec.reg_we = 1'b0;
   end

   // load in execute feeding the instruction in decode
   assign o_stall = i_if_id.valid && id_ex_q.valid && id_ex_q.is_load && id_ex_q.reg_we &&
                    (id_ex_q.rd == rs1 || id_ex_q.rd == rs2);

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         id_ex_q.valid <= 1'b0;
      else if (!i_hold)
      begin
         if (i_flush || o_stall)
            id_ex_q.valid <= 1'b0;
         else
            id_ex_q <= dec;
      end
   end

   assign o_id_ex = id_ex_q;

   // writeback must never aim at x0
   a_no_x0_write : assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wb_we |-> i_wb_rd != 5'd0)
      else $error("register write port targets x0");

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
// ============================================================
// execute stage: forwarding from memory stage, alu,
// branch and jal resolution, execute/memory register
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module rv_execute
   import rv_isa_pkg::*;
(
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire  id_ex_t     i_id_ex,
   input  wire              i_hold,
   input  wire              i_fwd_we,
   input  wire  [4:0]       i_fwd_rd,
   input  wire  [XLEN-1:0]  i_fwd_data,
   output ex_mem_t          o_ex_mem,
   output logic             o_redirect,
   output logic [XLEN-1:0]  o_target
);

   logic [XLEN-1:0] rs1_v;
   logic [XLEN-1:0] rs2_v;
   logic [XLEN-1:0] op_b;
   logic [XLEN-1:0] alu_res;
   logic            taken;
   ex_mem_t         ex_mem_q;

   // forward the value being written by the memory stage
   assign rs1_v = (i_fwd_we && i_fwd_rd != 5'd0 && i_fwd_rd == i_id_ex.rs1) ?
                  i_fwd_data : i_id_ex.rs1_data;
   assign rs2_v = (i_fwd_we && i_fwd_rd != 5'd0 && i_fwd_rd == i_id_ex.rs2) ?
                  i_fwd_data : i_id_ex.rs2_data;
   assign op_b  = i_id_ex.use_imm ? i_id_ex.imm : rs2_v;

   always_comb
   begin
      case (i_id_ex.alu_op)
         ALU_SUB:    alu_res = rs1_v - op_b;
         ALU_AND:    alu_res = rs1_v & op_b;
         ALU_OR:     alu_res = rs1_v | op_b;
         ALU_XOR:    alu_res = rs1_v ^ op_b;
         ALU_SLT:    alu_res = {31'd0, $signed(rs1_v) < $signed(op_b)};
         ALU_PASS_B: alu_res = op_b;
         default:    alu_res = rs1_v + op_b;
      endcase
   end

   // beq on equal, bne on not equal
   assign taken = i_id_ex.is_branch && ((rs1_v == rs2_v) ^ i_id_ex.branch_ne);

   // redirect only in the cycle the instruction leaves execute
   assign o_redirect = i_id_ex.valid && !i_hold && (taken || i_id_ex.is_jal);
   assign o_target   = i_id_ex.pc + i_id_ex.imm;

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         ex_mem_q.valid <= 1'b0;
      else if (!i_hold)
      begin
         ex_mem_q.valid      <= i_id_ex.valid;
         // jal links pc+4
         ex_mem_q.result     <= i_id_ex.is_jal ? i_id_ex.pc + 32'd4 : alu_res;
         ex_mem_q.store_data <= rs2_v;
         ex_mem_q.rd         <= i_id_ex.rd;
         ex_mem_q.reg_we     <= i_id_ex.reg_we;
         ex_mem_q.is_load    <= i_id_ex.is_load;
         ex_mem_q.is_store   <= i_id_ex.is_store;
      end
   end

   assign o_ex_mem = ex_mem_q;

   // decode has to drop the younger slot after a redirect
   a_flush_after_redirect : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_redirect |=> !i_id_ex.valid)
      else $error("instruction after a taken branch reached execute");

endmodule

`default_nettype wire

// ==== design/rv_mem_stage.sv ====
// ============================================================
// memory/writeback stage: word load/store master,
// busy back-pressure, register write port
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module rv_mem_stage
   import rv_isa_pkg::*, rv_bus_pkg::*;
(
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire  ex_mem_t    i_ex_mem,
   output logic             o_busy,
   output wb_req_t          o_wb,
   input  wire  wb_rsp_t    i_wb,
   output logic             o_wb_we,
   output logic [4:0]       o_wb_rd,
   output logic [XLEN-1:0]  o_wb_data
);

   logic mem_op;
   logic done;

   assign mem_op = i_ex_mem.valid && (i_ex_mem.is_load || i_ex_mem.is_store);

   // request comes from the held ex/mem register, so it is stable until ack
   always_comb
   begin
      o_wb = '0;
      if (mem_op)
      begin
         o_wb.cyc = 1'b1;
         o_wb.stb = 1'b1;
         o_wb.we  = i_ex_mem.is_store;
         o_wb.sel = SEL_WORD;
         o_wb.adr = i_ex_mem.result;
         o_wb.dat = i_ex_mem.store_data;
      end
   end

   // alu ops finish at once, memory ops on ack
   assign done   = !mem_op || i_wb.ack;
   assign o_busy = !done;

   // writeback and forwarding source
   assign o_wb_we   = i_ex_mem.valid && i_ex_mem.reg_we && done;
   assign o_wb_rd   = i_ex_mem.rd;
   assign o_wb_data = i_ex_mem.is_load ? i_wb.dat : i_ex_mem.result;

   // pipeline hold must keep the request unchanged while waiting
   a_req_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_wb.stb && !i_wb.ack |=> o_wb.stb && $stable(o_wb.adr) &&
                                $stable(o_wb.we) && $stable(o_wb.dat))
      else $error("data request changed before ack");

endmodule

`default_nettype wire

// ==== design/wb_arbiter.sv ====
// ============================================================
// two-master wishbone classic arbiter, data master first,
// grant locked for the whole bus cycle
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
   import rv_bus_pkg::*;
(
   input  wire            clk,
   input  wire            i_rst_n,
   input  wire  wb_req_t  i_fetch,
   output wb_rsp_t        o_fetch,
   input  wire  wb_req_t  i_data,
   output wb_rsp_t        o_data,
   output wb_req_t        o_bus,
   input  wire  wb_rsp_t  i_bus
);

   arb_state_e state_q;
   arb_state_e state_d;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         GNT_FETCH:
            // on ack hand over straight to a waiting data master
            if (i_bus.ack)
               state_d = i_data.cyc ? GNT_DATA : IDLE;
            else if (!i_fetch.cyc)
               state_d = IDLE;
         GNT_DATA:
            if (i_bus.ack)
               state_d = i_fetch.cyc ? GNT_FETCH : IDLE;
            else if (!i_data.cyc)
               state_d = IDLE;
         default:
            // data is the older instruction
            state_d = i_data.cyc ? GNT_DATA : (i_fetch.cyc ? GNT_FETCH : IDLE);
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // request mux, bus quiet while idle
   assign o_bus = (state_q == GNT_DATA)  ? i_data  :
                  (state_q == GNT_FETCH) ? i_fetch : '0;

   // ack only to the owner, read data shared
   assign o_fetch = '{ack: (state_q == GNT_FETCH) && i_bus.ack, dat: i_bus.dat};
   assign o_data  = '{ack: (state_q == GNT_DATA) && i_bus.ack, dat: i_bus.dat};

   a_ack_to_owner : assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_fetch.ack |-> i_fetch.cyc) and (o_data.ack |-> i_data.cyc))
      else $error("ack reached a master that has no bus cycle open");

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// ============================================================
// rv32i core top: fetch, decode, execute, memory stage
// and the shared wishbone arbiter
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
   import rv_isa_pkg::*, rv_bus_pkg::*;
(
   input  wire            clk,
   input  wire            i_rst_n,
   output wb_req_t        o_wb,
   input  wire  wb_rsp_t  i_wb
);

   if_id_t          if_id;
   id_ex_t          id_ex;
   ex_mem_t         ex_mem;
   wb_req_t         fetch_req;
   wb_rsp_t         fetch_rsp;
   wb_req_t         data_req;
   wb_rsp_t         data_rsp;
   logic            id_stall;
   logic            mem_busy;
   logic            fetch_stall;
   logic            redirect;
   logic [XLEN-1:0] target;
   logic            wb_we;
   logic [4:0]      wb_rd;
   logic [XLEN-1:0] wb_data;

   // fetch freezes on a load-use hazard or a waiting memory op
   assign fetch_stall = id_stall | mem_busy;

   rv_fetch fetch_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_stall    (fetch_stall),
      .i_redirect (redirect),
      .i_target   (target),
      .o_if_id    (if_id),
      .o_wb       (fetch_req),
      .i_wb       (fetch_rsp)
   );

   rv_decode decode_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_if_id   (if_id),
      .i_hold    (mem_busy),
      .i_flush   (redirect),
      .i_wb_we   (wb_we),
      .i_wb_rd   (wb_rd),
      .i_wb_data (wb_data),
      .o_id_ex   (id_ex),
      .o_stall   (id_stall)
   );

   rv_execute execute_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_id_ex    (id_ex),
      .i_hold     (mem_busy),
      .i_fwd_we   (wb_we),
      .i_fwd_rd   (wb_rd),
      .i_fwd_data (wb_data),
      .o_ex_mem   (ex_mem),
      .o_redirect (redirect),
      .o_target   (target)
   );

   rv_mem_stage mem_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_ex_mem  (ex_mem),
      .o_busy    (mem_busy),
      .o_wb      (data_req),
      .i_wb      (data_rsp),
      .o_wb_we   (wb_we),
      .o_wb_rd   (wb_rd),
      .o_wb_data (wb_data)
   );

   wb_arbiter arb_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_fetch (fetch_req),
      .o_fetch (fetch_rsp),
      .i_data  (data_req),
      .o_data  (data_rsp),
      .o_bus   (o_wb),
      .i_bus   (i_wb)
   );

endmodule

`default_nettype wire

// ==== tests/wb_mem_model.sv ====
// ============================================================
// wishbone classic slave memory for the core testbench,
// 1 KiB word array, random wait states from an lfsr
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
   import rv_bus_pkg::*;
(
   input  wire            clk,
   input  wire            i_rst_n,
   input  wire  wb_req_t  i_req,
   output wb_rsp_t        o_rsp
);

   localparam logic [31:0] LFSR_SEED = 32'haf960160;

   logic [31:0] mem [0:255];
   logic [31:0] lfsr_q;
   logic        busy_q;
   logic [1:0]  wait_q;

   // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // preload one word, used by the testbench before reset ends
   task automatic write_word(input logic [31:0] adr, input logic [31:0] dat);
      mem[adr[9:2]] = dat;
   endtask

   // fill with a value that carries the byte address
   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hdead0000 | (32'(i) << 2);
   end

   always @(posedge clk)
   begin
      logic [31:0] s1;
      logic [31:0] s2;
      if (!i_rst_n)
      begin
         o_rsp  <= '0;
         busy_q <= 1'b0;
         wait_q <= 2'd0;
         lfsr_q <= LFSR_SEED;
      end
      else
      begin
         // ack is a single-cycle pulse
         o_rsp.ack <= 1'b0;
         if (i_req.cyc && i_req.stb && !o_rsp.ack)
         begin
            if (!busy_q)
            begin
               // new transfer, draw two bits for 0..3 wait states
               s1 = lfsr_step(lfsr_q);
               s2 = lfsr_step(s1);
               lfsr_q <= s2;
               wait_q <= {s1[0], s2[0]};
               busy_q <= 1'b1;
            end
            else if (wait_q == 2'd0)
            begin
               o_rsp.ack <= 1'b1;
               busy_q    <= 1'b0;
               if (i_req.we)
                  mem[i_req.adr[9:2]] = i_req.dat;
               else
                  o_rsp.dat <= mem[i_req.adr[9:2]];
            end
            else
               wait_q <= wait_q - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
// ============================================================
// testbench for the core with clock, reset, pattern loading,
// store checking against the expected list and a bus monitor
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
   import rv_isa_pkg::*, rv_bus_pkg::*;
;

   localparam int FIRST_REQ_TIMEOUT = 100;
   localparam int STORE_TIMEOUT     = 5000;
   localparam int TAIL_CYCLES       = 50;

   logic        clk;
   logic        rst_n;
   wb_req_t     bus_req;
   wb_rsp_t     bus_rsp;

   // expected stores in program order
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];

   // stability tracking for an open transfer
   logic        prev_wait;
   wb_req_t     prev_req;

   rv_core_top dut_i (
      .clk     (clk),
      .i_rst_n (rst_n),
      .o_wb    (bus_req),
      .i_wb    (bus_rsp)
   );

   wb_mem_model mem_model_i (
      .clk     (clk),
      .i_rst_n (rst_n),
      .i_req   (bus_req),
      .o_rsp   (bus_rsp)
   );

   always #10 clk = ~clk;

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // P lines go into memory, S lines into the expected store list
   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] d;
      fd = $fopen("tests/core_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("Simulation failed");
         $fatal(1, "could not open the pattern file tests/core_patterns.txt");
      end
      while ($fgets(line, fd) != 0)
      begin
         // skip comments and blank lines
         if (line.len() < 5 || line[0] == "#")
            continue;
         n = $sscanf(line, "%c %h %h", kind, a, d);
         if (n == 3 && kind == "P")
            mem_model_i.write_word(a, d);
         else if (n == 3 && kind == "S")
         begin
            exp_adr.push_back(a);
            exp_dat.push_back(d);
         end
      end
      $fclose(fd);
   endtask

   // bus rules and store capture at the rising edge
   always @(posedge clk)
   begin
      if (!rst_n)
         prev_wait = 1'b0;
      else
      begin
         if (bus_req.stb && !bus_req.cyc)
         begin
            $display("Simulation failed");
            $fatal(1, "bus rule broken: stb is high while cyc is low");
         end
         // every access of this core is a full word
         if (bus_req.stb)
            check_value("request sel", 32'(bus_req.sel), 32'h0000000f);
         if (prev_wait)
         begin
            if (!bus_req.stb || bus_req.adr != prev_req.adr ||
                bus_req.we != prev_req.we || bus_req.sel != prev_req.sel ||
                bus_req.dat != prev_req.dat)
            begin
               $display("Simulation failed");
               $fatal(1, "bus rule broken: request changed or dropped before ack");
            end
         end
         prev_wait = bus_req.stb && !bus_rsp.ack;
         prev_req  = bus_req;

         // a store completes on its ack
         if (bus_req.cyc && bus_req.stb && bus_req.we && bus_rsp.ack)
         begin
            if (exp_adr.size() == 0)
            begin
               $display("Simulation failed");
               $fatal(1, "the core wrote memory when no more stores were expected");
            end
            check_value("store address", bus_req.adr, exp_adr[0]);
            check_value("store data", bus_req.dat, exp_dat[0]);
            void'(exp_adr.pop_front());
            void'(exp_dat.pop_front());
         end
      end
   end

   initial
   begin
      int cycles;
      clk       = 1'b0;
      rst_n     = 1'b0;
      prev_wait = 1'b0;
      prev_req  = '0;
      @(posedge clk);
      load_patterns();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // bus stays quiet in the first cycle out of reset
      @(posedge clk);
      check_value("cyc after reset", 32'(bus_req.cyc), 32'd0);
      check_value("stb after reset", 32'(bus_req.stb), 32'd0);

      // first request is an instruction read at the reset pc
      cycles = 0;
      while (!bus_req.stb)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > FIRST_REQ_TIMEOUT)
         begin
            $display("Simulation failed");
            $fatal(1, "timeout: no bus request after reset");
         end
      end
      check_value("first request address", bus_req.adr, RESET_PC);
      check_value("first request we", 32'(bus_req.we), 32'd0);

      // wait until every expected store was seen
      cycles = 0;
      while (exp_adr.size() != 0)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > STORE_TIMEOUT)
         begin
            $display("Simulation failed");
            $fatal(1, "timeout: %0d expected stores never happened", exp_adr.size());
         end
      end

      // any further store is caught by the monitor
      repeat (TAIL_CYCLES) @(posedge clk);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/core_patterns.txt ====
# P <byte address> <word>: preload memory (program and data)
# S <byte address> <data>: expected store, in program order
P 00000000 00500093
P 00000004 00700113
P 00000008 002081b3
P 0000000c 40118233
P 00000010 002242b3
P 00000014 0032e2b3
P 00000018 0041f333
P 0000001c 0020a3b3
P 00000020 20000413
P 00000024 00342023
P 00000028 00442223
P 0000002c 00542423
P 00000030 00642623
P 00000034 00742823
P 00000038 123454b7
P 0000003c 00942a23
P 00000040 10042503
P 00000044 00150593
P 00000048 00b42c23
P 0000004c fff00613
P 00000050 00108663
P 00000054 00c42e23
P 00000058 00c42e23
P 0000005c 00109463
P 00000060 00242e23
P 00000064 00c006ef
P 00000068 02c42023
P 0000006c 02c42023
P 00000070 02d42023
P 00000074 01c42703
P 00000078 00e707b3
P 0000007c 02f42223
P 00000080 0000006f
P 00000300 00001000
S 00000200 0000000c
S 00000204 00000007
S 00000208 0000000c
S 0000020c 00000004
S 00000210 00000001
S 00000214 12345000
S 00000218 00001001
S 0000021c 00000007
S 00000220 00000068
S 00000224 0000000e

// ==== rv_core.f ====
design/rv_isa_pkg.sv
design/rv_bus_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_stage.sv
design/wb_arbiter.sv
design/rv_core_top.sv
tests/wb_mem_model.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
   --top-module tb_rv_core -f rv_core.f
./obj_dir/Vtb_rv_core
